//--- design/core_monitor.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module core_monitor (
   input  logic                   clk,
   input  logic                   reset_i,
   input  trace_pkg::trace_exec_t trace_i,
   output trace_pkg::mon_event_t  event_o
);

   import trace_pkg::*;

   localparam reg_addr_t ARG_REG = `TRACE_ARG_REG;

   // Run state
   core_state_e state_q;
   core_state_e state_d;

   // Shadow copy of r3
   word_t r3_q;

   // Decode of the current trace entry
   logic        accept;
   logic        is_nop;
   logic        nop_hit;
   event_kind_e nop_kind;
   logic        r3_wr;

   // Registered event
   logic        ev_valid_q;
   event_kind_e ev_kind_q;
   word_t       ev_value_q;

   // Traces only count while the core still runs
   assign accept = trace_i.valid && (state_q == CORE_RUN);

   // Writeback into r3 updates the shadow
   assign r3_wr = accept && trace_i.wben && (trace_i.wbreg == ARG_REG);

   assign is_nop = (trace_i.insn[31:16] == `TRACE_NOP_OPCODE);

   // No-op code to event kind, unknown codes give nothing
   always_comb begin
      nop_hit  = 1'b0;
      nop_kind = EV_PUTC;
      if (is_nop) begin
         case (trace_i.insn[15:0])
            `TRACE_NOP_EXIT: begin
               nop_hit  = 1'b1;
               nop_kind = EV_EXIT;
            end
            `TRACE_NOP_REPORT: begin
               nop_hit  = 1'b1;
               nop_kind = EV_REPORT;
            end
            `TRACE_NOP_PUTC: begin
               nop_hit  = 1'b1;
               nop_kind = EV_PUTC;
            end
            default: begin
               nop_hit = 1'b0;
            end
         endcase
      end
   end

   // Exit ends the run, nothing brings the core back but reset
   always_comb begin
      state_d = state_q;
      case (state_q)
         CORE_RUN: begin
            if (accept && nop_hit && (nop_kind == EV_EXIT)) begin
               state_d = CORE_DONE;
            end
         end
         CORE_DONE: begin
            state_d = CORE_DONE;
         end
         default: begin
            state_d = CORE_RUN;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q    <= CORE_RUN;
         ev_valid_q <= 1'b0;
         r3_q       <= '0;
      end else begin
         state_q    <= state_d;
         ev_valid_q <= accept && nop_hit;
         if (r3_wr) begin
            r3_q <= trace_i.wbdata;
         end
      end
   end

   // Event value is r3 before this entry
   always_ff @(posedge clk) begin
      if (accept && nop_hit) begin
         ev_kind_q  <= nop_kind;
         ev_value_q <= r3_q;
      end
   end

   assign event_o = '{valid: ev_valid_q, kind: ev_kind_q, core: '0, value: ev_value_q};

endmodule

`default_nettype wire

//--- design/event_merge.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module event_merge (
   input  logic                                         clk,
   input  logic                                         reset_i,
   input  trace_pkg::mon_event_t [`TRACE_NUM_CORES-1:0] core_event_i,
   output trace_pkg::mon_event_t                        event_o,
   output logic                                         overflow_o
);

   import trace_pkg::*;

   localparam int NUM_CORES = `TRACE_NUM_CORES;
   localparam int DEPTH     = `TRACE_EVQ_DEPTH;
   localparam int PTR_W     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W     = $clog2(DEPTH + 1);

   // Queue status seen by the arbiter
   logic [CNT_W-1:0]     q_count [NUM_CORES];
   mon_event_t           q_head  [NUM_CORES];
   logic [NUM_CORES-1:0] q_drop;
   logic [NUM_CORES-1:0] q_pop;

   // Round-robin state, last core served
   core_id_t rr_q;
   core_id_t sel_core;
   logic     sel_found;

   // Output register
   logic        out_valid_q;
   event_kind_e out_kind_q;
   core_id_t    out_core_q;
   word_t       out_value_q;
   logic        overflow_q;

   genvar c;
   generate
      for (c = 0; c < NUM_CORES; c++) begin : gen_queue
         mon_event_t       mem [DEPTH];
         logic [PTR_W-1:0] wptr_q;
         logic [PTR_W-1:0] rptr_q;
         logic [CNT_W-1:0] count_q;
         logic             full;
         logic             push;

         assign full = (count_q == CNT_W'(DEPTH));
         // Full queue drops the new event
         assign push      = core_event_i[c].valid && !full;
         assign q_drop[c] = core_event_i[c].valid && full;

         assign q_count[c] = count_q;
         assign q_head[c]  = mem[rptr_q];

         always_ff @(posedge clk) begin
            if (push) begin
               mem[wptr_q] <= core_event_i[c];
            end
         end

         // Pointers wrap at DEPTH, which need not be a power of two
         always_ff @(posedge clk) begin
            if (reset_i) begin
               wptr_q  <= '0;
               rptr_q  <= '0;
               count_q <= '0;
            end else begin
               if (push) begin
                  wptr_q <= (wptr_q == PTR_W'(DEPTH - 1)) ? '0 : wptr_q + 1'b1;
               end
               if (q_pop[c]) begin
                  rptr_q <= (rptr_q == PTR_W'(DEPTH - 1)) ? '0 : rptr_q + 1'b1;
               end
               count_q <= count_q + CNT_W'(push) - CNT_W'(q_pop[c]);
            end
         end
      end
   endgenerate

   // Search starts at the core after the last one served
   always_comb begin
      core_id_t cand;
      sel_found = 1'b0;
      sel_core  = rr_q;
      q_pop     = '0;
      for (int k = 1; k <= NUM_CORES; k++) begin
         cand = core_id_t'((int'(rr_q) + k) % NUM_CORES);
         if (!sel_found && (q_count[cand] != '0)) begin
            sel_found = 1'b1;
            sel_core  = cand;
         end
      end
      if (sel_found) begin
         q_pop[sel_core] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         // Core 0 gets the first turn
         rr_q        <= core_id_t'(NUM_CORES - 1);
         out_valid_q <= 1'b0;
         overflow_q  <= 1'b0;
      end else begin
         out_valid_q <= sel_found;
         if (sel_found) begin
            rr_q <= sel_core;
         end
         // Sticky once any event is lost
         if (|q_drop) begin
            overflow_q <= 1'b1;
         end
      end
   end

   // Payload with the core number taken from the queue index
   always_ff @(posedge clk) begin
      if (sel_found) begin
         out_kind_q  <= q_head[sel_core].kind;
         out_core_q  <= sel_core;
         out_value_q <= q_head[sel_core].value;
      end
   end

   assign event_o = '{valid: out_valid_q, kind: out_kind_q, core: out_core_q,
                      value: out_value_q};
   assign overflow_o = overflow_q;

endmodule

`default_nettype wire

//--- design/termination_tracker.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module termination_tracker (
   input  logic                                     clk,
   input  logic                                     reset_i,
   input  logic [`TRACE_NUM_CORES-1:0]              exit_i,
   input  trace_pkg::word_t [`TRACE_NUM_CORES-1:0]  exit_code_i,
   output logic [`TRACE_NUM_CORES-1:0]              done_o,
   output logic                                     all_done_o,
   output logic                                     fail_o
);

   localparam int NUM_CORES = `TRACE_NUM_CORES;

   // One bit per core that has exited
   logic [NUM_CORES-1:0] done_q;

   // Exits with a nonzero code in this cycle
   logic [NUM_CORES-1:0] bad_exit;

   logic fail_q;

   always_comb begin
      for (int k = 0; k < NUM_CORES; k++) begin
         bad_exit[k] = exit_i[k] && (exit_code_i[k] != '0);
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         done_q <= '0;
         fail_q <= 1'b0;
      end else begin
         // Done bits only ever rise
         done_q <= done_q | exit_i;
         // One failing core fails the whole run
         if (|bad_exit) begin
            fail_q <= 1'b1;
         end
      end
   end

   assign done_o = done_q;

   // All cores terminated
   assign all_done_o = &done_q;

   assign fail_o = fail_q;

endmodule

`default_nettype wire

//--- design/trace_monitor_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module trace_monitor_top (
   input  logic                                          clk,
   input  logic                                          reset_i,
   input  trace_pkg::trace_exec_t [`TRACE_NUM_CORES-1:0] trace_i,
   output trace_pkg::mon_event_t                         event_o,
   output logic                                          overflow_o,
   output logic [`TRACE_NUM_CORES-1:0]                   done_o,
   output logic                                          all_done_o,
   output logic                                          fail_o
);

   import trace_pkg::*;

   // Events straight out of each core monitor
   mon_event_t [`TRACE_NUM_CORES-1:0] core_event;

   // Exit strobe and code per core for the tracker
   logic [`TRACE_NUM_CORES-1:0]  core_exit;
   word_t [`TRACE_NUM_CORES-1:0] core_exit_code;

   genvar k;
   generate
      for (k = 0; k < `TRACE_NUM_CORES; k++) begin : gen_core
         core_monitor u_core_monitor (
            .clk     (clk),
            .reset_i (reset_i),
            .trace_i (trace_i[k]),
            .event_o (core_event[k])
         );

         // Exit event doubles as termination strobe
         assign core_exit[k]      = core_event[k].valid && (core_event[k].kind == EV_EXIT);
         assign core_exit_code[k] = core_event[k].value;
      end
   endgenerate

   // All cores into one stream
   event_merge u_event_merge (
      .clk          (clk),
      .reset_i      (reset_i),
      .core_event_i (core_event),
      .event_o      (event_o),
      .overflow_o   (overflow_o)
   );

   termination_tracker u_termination_tracker (
      .clk         (clk),
      .reset_i     (reset_i),
      .exit_i      (core_exit),
      .exit_code_i (core_exit_code),
      .done_o      (done_o),
      .all_done_o  (all_done_o),
      .fail_o      (fail_o)
   );

endmodule

`default_nettype wire

//--- design/trace_pkg.sv
`default_nettype none

package trace_pkg;

   // Data word: pc, instruction, writeback data, r3, event value
   typedef logic [31:0] word_t;

   // Register file index
   typedef logic [4:0] reg_addr_t;

   // Core number, four cores at most
   typedef logic [1:0] core_id_t;

   // One retired instruction as seen at writeback
   typedef struct packed {
      logic      valid;
      word_t     pc;
      word_t     insn;
      logic      wben;
      reg_addr_t wbreg;
      word_t     wbdata;
   } trace_exec_t;

   // Kind of no-op seen in the trace
   typedef enum logic [1:0] {
      EV_PUTC   = 2'd0,
      EV_REPORT = 2'd1,
      EV_EXIT   = 2'd2
   } event_kind_e;

   // Monitor event
   // core is filled in by the merge, zero out of a core monitor
   typedef struct packed {
      logic        valid;
      event_kind_e kind;
      core_id_t    core;
      word_t       value;
   } mon_event_t;

   // Per-core run state
   typedef enum logic {
      CORE_RUN  = 1'b0,
      CORE_DONE = 1'b1
   } core_state_e;

endpackage

`default_nettype wire

//--- include/trace_params.svh
`ifndef TRACE_PARAMS_SVH
`define TRACE_PARAMS_SVH

// Number of cores whose traces are watched
`define TRACE_NUM_CORES 4

// Entries per core in the event queue of the merge
`define TRACE_EVQ_DEPTH 4

// Upper instruction half that marks a simulation no-op
`define TRACE_NOP_OPCODE 16'h1500

// Lower instruction half selects the no-op function
`define TRACE_NOP_EXIT   16'h0001
`define TRACE_NOP_REPORT 16'h0002
`define TRACE_NOP_PUTC   16'h0004

// Register that carries the no-op argument
`define TRACE_ARG_REG 5'd3

`endif

//--- run_sim.sh
#!/bin/sh
# Build and run the trace monitor testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
   -f verilog.f --top-module tb_trace_monitor -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
   cat "$BUILD_LOG"
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
   echo "Simulation returned status $status"
   exit 1
fi

if grep -q "Something failed" "$SIM_LOG"; then
   echo "Simulation reported a failure"
   exit 1
fi
echo "Simulation passed"
exit 0

//--- tests/tb_trace_monitor.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module tb_trace_monitor;

   import trace_pkg::*;

   localparam int NUM_CORES  = `TRACE_NUM_CORES;
   localparam int WAIT_LIMIT = 4000;

   logic                        clk;
   logic                        reset;
   logic                        check_end;
   trace_exec_t [NUM_CORES-1:0] trace;
   mon_event_t  [NUM_CORES-1:0] exp_event;
   mon_event_t                  dut_event;
   logic                        overflow;
   logic [NUM_CORES-1:0]        done;
   logic                        all_done;
   logic                        fail;
   int                          pending;
   int                          events;
   int                          errors;
   int                          timeouts;

   // Reference model, one slot per core
   integer seed;
   word_t  r3_m     [NUM_CORES];
   int     count_m  [NUM_CORES];
   int     target_m [NUM_CORES];
   int     cool_m   [NUM_CORES];
   logic   done_m   [NUM_CORES];
   int     fail_core;
   word_t  fail_code;

   trace_monitor_top UUT (
      .clk        (clk),
      .reset_i    (reset),
      .trace_i    (trace),
      .event_o    (dut_event),
      .overflow_o (overflow),
      .done_o     (done),
      .all_done_o (all_done),
      .fail_o     (fail)
   );

   trace_checker u_checker (
      .clk         (clk),
      .reset_i     (reset),
      .exp_event_i (exp_event),
      .event_i     (dut_event),
      .overflow_i  (overflow),
      .done_i      (done),
      .all_done_i  (all_done),
      .fail_i      (fail),
      .check_end_i (check_end),
      .pending_o   (pending),
      .events_o    (events),
      .errors_o    (errors)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   // One clock of traces on every core, model follows along
   task automatic drive_cycle();
      trace_exec_t [NUM_CORES-1:0] tr;
      mon_event_t  [NUM_CORES-1:0] ex;
      int                          pick;
      tr = '0;
      ex = '0;
      for (int c = 0; c < NUM_CORES; c++) begin
         if (cool_m[c] > 0) cool_m[c]--;
         pick        = rand_below(8);
         tr[c].valid = (rand_below(4) != 0);
         tr[c].pc    = word_t'($random(seed));
         // Bit 31 set, never mistaken for a no-op
         tr[c].insn  = word_t'($random(seed)) | 32'h8000_0000;
         if (tr[c].valid && !done_m[c] && count_m[c] == target_m[c]) begin
            // Exit code lands in r3 just before the exit
            tr[c].wben   = 1'b1;
            tr[c].wbreg  = 5'd3;
            tr[c].wbdata = (c == fail_core) ? fail_code : '0;
            r3_m[c]      = tr[c].wbdata;
         end else if (tr[c].valid && !done_m[c] && count_m[c] > target_m[c]) begin
            if (cool_m[c] == 0) begin
               tr[c].insn = {`TRACE_NOP_OPCODE, `TRACE_NOP_EXIT};
               ex[c]      = '{valid: 1'b1, kind: EV_EXIT, core: core_id_t'(c), value: r3_m[c]};
               done_m[c]  = 1'b1;
            end
         end else if (tr[c].valid && pick < 2 && cool_m[c] == 0) begin
            // putc or report, silent once the core has exited
            tr[c].insn = {`TRACE_NOP_OPCODE, (pick == 0) ? `TRACE_NOP_PUTC : `TRACE_NOP_REPORT};
            if (!done_m[c]) begin
               ex[c] = '{valid: 1'b1, kind: (pick == 0) ? EV_PUTC : EV_REPORT,
                         core: core_id_t'(c), value: r3_m[c]};
               // Spacing keeps the core's queue well below full
               cool_m[c] = 6;
            end
         end else if (tr[c].valid && pick >= 2 && pick <= 4) begin
            // Register write, one in three to r3
            tr[c].wben   = 1'b1;
            tr[c].wbreg  = (pick == 2) ? 5'd3 : reg_addr_t'(4 + rand_below(28));
            tr[c].wbdata = word_t'($random(seed));
            if (!done_m[c] && pick == 2) r3_m[c] = tr[c].wbdata;
         end else if (tr[c].valid && pick == 5) begin
            // Unknown no-op code gives no event
            tr[c].insn = {`TRACE_NOP_OPCODE, 16'h0008};
         end
         if (tr[c].valid && !done_m[c]) count_m[c]++;
      end
      trace     <= tr;
      exp_event <= ex;
   endtask

   task automatic run_phase(input int bad_core);
      int waited;
      fail_core = bad_core;
      fail_code = word_t'($random(seed)) | 32'h1;
      for (int c = 0; c < NUM_CORES; c++) begin
         r3_m[c]     = '0;
         count_m[c]  = 0;
         target_m[c] = 40 + rand_below(81);
         cool_m[c]   = 0;
         done_m[c]   = 1'b0;
      end
      reset     <= 1'b1;
      trace     <= '0;
      exp_event <= '0;
      repeat (2) @(posedge clk);
      reset  <= 1'b0;
      waited = 0;
      while (!all_done && waited < WAIT_LIMIT) begin
         @(posedge clk);
         drive_cycle();
         waited++;
      end
      if (!all_done) begin
         $display("Timeout: not every core reported done within %0d cycles", WAIT_LIMIT);
         timeouts++;
      end
      // Drain the merge, finished cores keep tracing meanwhile
      waited = 0;
      while (pending != 0 && waited < WAIT_LIMIT) begin
         @(posedge clk);
         drive_cycle();
         waited++;
      end
      if (pending != 0) begin
         $display("Timeout: %0d expected events still missing after the drain", pending);
         timeouts++;
      end
      // Room for stray events to show up
      repeat (8) begin
         @(posedge clk);
         drive_cycle();
      end
      @(posedge clk);
      trace     <= '0;
      exp_event <= '0;
      check_end <= 1'b1;
      @(posedge clk);
      check_end <= 1'b0;
   endtask

   initial begin
      seed      = 32'h45c4_a2ea;
      reset     = 1'b1;
      check_end = 1'b0;
      trace     = '0;
      exp_event = '0;
      timeouts  = 0;
      // All exit codes zero here
      run_phase(NUM_CORES);
      // One core exits with a nonzero code
      run_phase(rand_below(NUM_CORES));
      @(posedge clk);
      $display("Summary: %0d events checked, %0d errors, %0d timeouts", events, errors,
               timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/trace_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module trace_checker (
   input  logic                                         clk,
   input  logic                                         reset_i,
   input  trace_pkg::mon_event_t [`TRACE_NUM_CORES-1:0] exp_event_i,
   input  trace_pkg::mon_event_t                        event_i,
   input  logic                                         overflow_i,
   input  logic [`TRACE_NUM_CORES-1:0]                  done_i,
   input  logic                                         all_done_i,
   input  logic                                         fail_i,
   input  logic                                         check_end_i,
   output int                                           pending_o,
   output int                                           events_o,
   output int                                           errors_o
);

   import trace_pkg::*;

   localparam int NUM_CORES = `TRACE_NUM_CORES;

   // Expected events of all cores in issue order per core
   mon_event_t           exp_q [$];
   logic [NUM_CORES-1:0] exp_done;
   logic                 exp_fail;
   logic                 reset_q;
   int                   errors;
   int                   events;

   // Oldest expected entry of one core or -1 if none
   function automatic int oldest_of(input core_id_t core);
      oldest_of = -1;
      for (int i = exp_q.size() - 1; i >= 0; i--) begin
         if (exp_q[i].core == core) oldest_of = i;
      end
   endfunction

   task automatic report_mismatch(input string what, input word_t got, input word_t want);
      $display("[ERROR] %0t: %s, got %0h, expected %0h", $time, what, got, want);
      errors++;
   endtask

   always @(posedge clk) begin
      int         idx;
      mon_event_t want;
      word_t      after_reset;
      if (reset_i) begin
         exp_q.delete();
         exp_done = '0;
         exp_fail = 1'b0;
      end else begin
         // First edge out of reset sees the reset values
         if (reset_q) begin
            after_reset = word_t'({event_i.valid, overflow_i, all_done_i, fail_i, done_i});
            if (after_reset != '0) begin
               report_mismatch("outputs right after reset", after_reset, '0);
            end
         end
         for (int c = 0; c < NUM_CORES; c++) begin
            if (exp_event_i[c].valid) begin
               exp_q.push_back(exp_event_i[c]);
               if (exp_event_i[c].kind == EV_EXIT) begin
                  exp_done[c] = 1'b1;
                  if (exp_event_i[c].value != '0) exp_fail = 1'b1;
               end
            end
         end
         if (event_i.valid) begin
            events++;
            idx = oldest_of(event_i.core);
            if (idx < 0) begin
               $display("[ERROR] %0t: extra event on core %0d with value %0h", $time,
                        event_i.core, event_i.value);
               errors++;
            end else begin
               want = exp_q[idx];
               exp_q.delete(idx);
               if (event_i.kind != want.kind)
                  report_mismatch($sformatf("core %0d event kind", event_i.core),
                                  word_t'(event_i.kind), word_t'(want.kind));
               if (event_i.value != want.value)
                  report_mismatch($sformatf("core %0d event value", event_i.core),
                                  event_i.value, want.value);
            end
         end
         if (overflow_i) report_mismatch("overflow_o", 1, 0);
         // Done may lag the expected exit but never lead it
         if ((done_i & ~exp_done) != '0) report_mismatch("done_o ahead of exits", done_i, exp_done);
         if (fail_i && !exp_fail) report_mismatch("fail_o without a bad exit", 1, 0);
         if (check_end_i) begin
            if (exp_q.size() != 0) begin
               $display("[ERROR] %0t: %0d expected events never appeared", $time, exp_q.size());
               errors++;
            end
            if (done_i != exp_done) report_mismatch("done_o at end", done_i, exp_done);
            if (all_done_i != &exp_done) report_mismatch("all_done_o", all_done_i, &exp_done);
            if (fail_i != exp_fail) report_mismatch("fail_o at end", fail_i, exp_fail);
         end
      end
      reset_q = reset_i;
      pending_o <= exp_q.size();
      events_o  <= events;
      errors_o  <= errors;
   end

endmodule

`default_nettype wire

//--- tests/trace_monitor_sva.sv
`default_nettype none
`timescale 1ns/1ps

`include "trace_params.svh"

module trace_monitor_sva (
   input logic                          clk,
   input logic                          reset_i,
   input trace_pkg::mon_event_t         event_i,
   input logic                          overflow_i,
   input logic [`TRACE_NUM_CORES-1:0]   done_i
);

   import trace_pkg::*;

   // Done bits only rise between resets
   done_hold: assert property (@(posedge clk) disable iff (reset_i)
      !$past(reset_i) |-> ((done_i & $past(done_i)) == $past(done_i)))
      else $error("done_o bit fell without reset");

   // Spaced stimulus never fills a queue
   no_overflow: assert property (@(posedge clk) disable iff (reset_i) !overflow_i)
      else $error("overflow_o went high");

   kind_known: assert property (@(posedge clk) disable iff (reset_i)
      event_i.valid |-> (event_i.kind inside {EV_PUTC, EV_REPORT, EV_EXIT}))
      else $error("event_o valid with an undefined kind");

endmodule

bind trace_monitor_top trace_monitor_sva u_sva (
   .clk        (clk),
   .reset_i    (reset_i),
   .event_i    (event_o),
   .overflow_i (overflow_o),
   .done_i     (done_o)
);

`default_nettype wire

//--- verilog.f
+incdir+include
design/trace_pkg.sv
design/core_monitor.sv
design/event_merge.sv
design/termination_tracker.sv
design/trace_monitor_top.sv
tests/trace_monitor_sva.sv
tests/trace_checker.sv
tests/tb_trace_monitor.sv
